// File: verilog/buffer_pkg.sv
// Shared types and default sizes for the byte-stream buffer
// Data width is fixed at one byte; depth and thresholds are module parameters
// DEF_DEPTH must be a power of two, DEF_BURST_LEN no greater than DEF_ALMOST_FULL

package buffer_pkg;

    // One byte of the stream
    typedef logic [7:0] byte_t;

    // Drain controller states
    typedef enum logic [1:0] {
        IDLE  = 2'd0, // Waiting for a threshold or a flush
        BURST = 2'd1, // Fixed-length burst
        FLUSH = 2'd2  // Drain until empty
    } drain_state_t;

    // FIFO depth in words
    localparam int DEF_DEPTH = 64;

    // almost_full is high at or above this level
    localparam int DEF_ALMOST_FULL = 48;

    // almost_empty is high at or below this level
    localparam int DEF_ALMOST_EMPTY = 8;

    // Words per normal burst
    // Kept at or below DEF_ALMOST_FULL so a burst never runs dry
    localparam int DEF_BURST_LEN = 16;

endpackage

// File: verilog/fifo_ram.sv
// Simple dual-port memory with a registered read port
// Read register loads every edge, so it maps onto block RAM
// No reset on the array or the read register

`timescale 1ns/1ps

module fifo_ram #(
    parameter int DEPTH  = 64,
    parameter int ADDR_W = 6
) (
    input  logic                clk,
    input  logic                we,      // Write strobe, already qualified
    input  logic [ADDR_W-1:0]   wr_addr,
    input  buffer_pkg::byte_t   wr_data,
    input  logic [ADDR_W-1:0]   rd_addr,
    output buffer_pkg::byte_t   rd_data  // Word at rd_addr of the previous edge
);

    buffer_pkg::byte_t mem [DEPTH]; // Storage array

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port, unconditional load
    // Caller moves rd_addr only after the word is captured
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: verilog/fifo_sync.sv
// Single-clock FIFO controller around fifo_ram
// DEPTH must be a power of two; pointers wrap without compare
// Writes when full and reads when empty are ignored
// Read data appears one cycle after an accepted read

`timescale 1ns/1ps

module fifo_sync #(
    parameter int DEPTH        = 64,
    parameter int ALMOST_FULL  = 48,
    parameter int ALMOST_EMPTY = 8
) (
    input  logic              clk,
    input  logic              rst,          // Active low, synchronous
    input  logic              wr_en,
    input  buffer_pkg::byte_t wr_data,
    input  logic              rd_en,
    output buffer_pkg::byte_t rd_data,
    output logic              full,
    output logic              almost_full,
    output logic              empty,
    output logic              almost_empty
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int CNT_W  = ADDR_W + 1;     // Holds 0..DEPTH

    logic [ADDR_W-1:0] wr_ptr;              // Next slot to write
    logic [ADDR_W-1:0] rd_ptr;              // Oldest stored word
    logic [CNT_W-1:0]  count;               // Words currently held

    logic wr_ok;                            // Accepted write this edge
    logic rd_ok;                            // Accepted read this edge

    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    // Flags straight from the occupancy count
    assign full         = (count == CNT_W'(DEPTH));
    assign empty        = (count == '0);
    assign almost_full  = (count >= CNT_W'(ALMOST_FULL));
    assign almost_empty = (count <= CNT_W'(ALMOST_EMPTY));

    // Occupancy
    always_ff @(posedge clk) begin
        if (!rst) begin
            count <= '0;
        end else if (wr_ok && !rd_ok) begin
            count <= count + 1'b1;  // Push only
        end else if (rd_ok && !wr_ok) begin
            count <= count - 1'b1;  // Pop only
        end
        // Push and pop together leave it alone
    end

    // Write pointer
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
        end else if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Read pointer
    // RAM captures mem[rd_ptr] at the same edge this one moves on
    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_ptr <= '0;
        end else if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    fifo_ram #(
        .DEPTH  (DEPTH),
        .ADDR_W (ADDR_W)
    ) u_fifo_ram (
        .clk     (clk),
        .we      (wr_ok),
        .wr_addr (wr_ptr),
        .wr_data (wr_data),
        .rd_addr (rd_ptr),
        .rd_data (rd_data)
    );

endmodule

// File: verilog/burst_drain.sv
// Burst read controller for fifo_sync
// Normal burst reads exactly BURST_LEN words once almost_full is seen
// Flush burst reads until empty; hold only blocks the start of a burst
// No back-pressure on the output side

`timescale 1ns/1ps

module burst_drain #(
    parameter int BURST_LEN = 16
) (
    input  logic              clk,
    input  logic              rst,         // Active low, synchronous
    input  logic              almost_full,
    input  logic              empty,
    input  logic              flush,       // One-cycle request
    input  logic              hold,        // Downstream not ready, level
    output logic              rd_en,
    input  buffer_pkg::byte_t rd_data,
    output logic              out_valid,
    output buffer_pkg::byte_t out_data,
    output logic              out_last,
    output logic              busy
);

    localparam int CNT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

    buffer_pkg::drain_state_t state, state_next;

    logic [CNT_W-1:0] word_cnt;    // Reads issued in this burst
    logic             flush_pend;  // Flush seen but not yet served
    logic             flush_req;
    logic             burst_end;   // Final read of a normal burst
    logic             last_q;      // Registered end marker, normal burst
    logic             flush_rd_q;  // Word on the output came from a flush read

    assign flush_req = flush || flush_pend;

    // Never read an empty FIFO
    assign rd_en = ((state == buffer_pkg::BURST) || (state == buffer_pkg::FLUSH)) && !empty;

    assign burst_end = (state == buffer_pkg::BURST) && rd_en &&
                       (word_cnt == CNT_W'(BURST_LEN - 1));

    always_comb begin
        state_next = state;
        case (state)
            buffer_pkg::IDLE: begin
                if (!hold) begin
                    if (flush_req) begin
                        state_next = buffer_pkg::FLUSH;  // Flush wins over threshold
                    end else if (almost_full) begin
                        state_next = buffer_pkg::BURST;
                    end
                end
            end
            buffer_pkg::BURST: begin
                if (burst_end) state_next = buffer_pkg::IDLE;
            end
            buffer_pkg::FLUSH: begin
                if (empty) state_next = buffer_pkg::IDLE; // Last read already done
            end
            default: state_next = buffer_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= buffer_pkg::IDLE;
            word_cnt   <= '0;
            flush_pend <= 1'b0;
        end else begin
            state <= state_next;

            if (state != buffer_pkg::BURST) begin
                word_cnt <= '0;
            end else if (rd_en) begin
                word_cnt <= word_cnt + 1'b1;
            end

            // Clear on entry to FLUSH, latch when it cannot be taken now
            if ((state == buffer_pkg::IDLE) && (state_next == buffer_pkg::FLUSH)) begin
                flush_pend <= 1'b0;
            end else if (flush && (state != buffer_pkg::FLUSH)) begin
                flush_pend <= 1'b1;
            end
        end
    end

    // Output strobes line up with the RAM read register
    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid  <= 1'b0;
            last_q     <= 1'b0;
            flush_rd_q <= 1'b0;
        end else begin
            out_valid  <= rd_en;
            last_q     <= burst_end;
            flush_rd_q <= rd_en && (state == buffer_pkg::FLUSH);
        end
    end

    assign out_data = rd_data;  // RAM register already holds this read's word

    // Empty now means that flush read took the final word
    assign out_last = out_valid && (last_q || (flush_rd_q && empty));

    // Covers the trailing word after the state has gone back to IDLE
    assign busy = (state != buffer_pkg::IDLE) || out_valid;

endmodule

// File: verilog/byte_stream_buffer.sv
// Byte-stream buffer, FIFO plus burst drain controller
// Writes while in_full is high are dropped
// Set ALMOST_FULL >= BURST_LEN and DEPTH to a power of two

`timescale 1ns/1ps

module byte_stream_buffer #(
    parameter int DEPTH        = buffer_pkg::DEF_DEPTH,
    parameter int ALMOST_FULL  = buffer_pkg::DEF_ALMOST_FULL,
    parameter int ALMOST_EMPTY = buffer_pkg::DEF_ALMOST_EMPTY,
    parameter int BURST_LEN    = buffer_pkg::DEF_BURST_LEN
) (
    input  logic              clk,
    input  logic              rst,        // Active low, synchronous
    input  logic              in_valid,   // Write strobe
    input  buffer_pkg::byte_t in_data,
    input  logic              flush,      // One-cycle pulse
    input  logic              hold,       // Blocks new bursts
    output logic              in_full,
    output logic              level_high, // At or above ALMOST_FULL
    output logic              level_low,  // At or below ALMOST_EMPTY
    output logic              out_valid,
    output buffer_pkg::byte_t out_data,
    output logic              out_last,
    output logic              busy
);

    logic              rd_en;
    buffer_pkg::byte_t rd_data;
    logic              empty;

    fifo_sync #(
        .DEPTH        (DEPTH),
        .ALMOST_FULL  (ALMOST_FULL),
        .ALMOST_EMPTY (ALMOST_EMPTY)
    ) u_fifo_sync (
        .clk          (clk),
        .rst          (rst),
        .wr_en        (in_valid),
        .wr_data      (in_data),
        .rd_en        (rd_en),
        .rd_data      (rd_data),
        .full         (in_full),
        .almost_full  (level_high),  // Also starts normal bursts
        .empty        (empty),
        .almost_empty (level_low)
    );

    burst_drain #(
        .BURST_LEN (BURST_LEN)
    ) u_burst_drain (
        .clk         (clk),
        .rst         (rst),
        .almost_full (level_high),
        .empty       (empty),
        .flush       (flush),
        .hold        (hold),
        .rd_en       (rd_en),
        .rd_data     (rd_data),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_last    (out_last),
        .busy        (busy)
    );

endmodule

// File: sim/byte_stream_buffer_properties.sv
// Flag and strobe rules, bound into the top level
// Checks are inactive while rst is low

`timescale 1ns/1ps

module byte_stream_buffer_properties (
    input logic clk,
    input logic rst,
    input logic full,
    input logic empty,
    input logic rd_en,
    input logic out_valid,
    input logic out_last
);

    int fail_count = 0;  // Failed assertions so far

    full_xor_empty: assert property (@(posedge clk) disable iff (!rst) !(full && empty))
        else begin
            $error("full and empty high together");
            fail_count++;
        end

    no_read_empty: assert property (@(posedge clk) disable iff (!rst) !(rd_en && empty))
        else begin
            $error("rd_en high while empty");
            fail_count++;
        end

    valid_after_read: assert property (@(posedge clk) disable iff (!rst)
                                       out_valid == $past(rd_en))
        else begin
            $error("out_valid not one cycle after rd_en");
            fail_count++;
        end

    last_with_valid: assert property (@(posedge clk) disable iff (!rst) out_last |-> out_valid)
        else begin
            $error("out_last without out_valid");
            fail_count++;
        end

endmodule

bind byte_stream_buffer byte_stream_buffer_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .full      (in_full),
    .empty     (empty),
    .rd_en     (rd_en),
    .out_valid (out_valid),
    .out_last  (out_last)
);

// File: sim/byte_stream_buffer_tb.sv
// Testbench for byte_stream_buffer with the default parameters
// Commands come from sim/buffer_patterns.txt, so run from the project root
// A queue model predicts the data order and the out_last positions
// Writes during a flush burst are not modelled

`timescale 1ns/1ps

module byte_stream_buffer_tb;

    localparam int DEPTH     = buffer_pkg::DEF_DEPTH;
    localparam int BURST_LEN = buffer_pkg::DEF_BURST_LEN;
    localparam int WAIT_MAX  = 1000;   // Cycle limit of each wait loop

    logic              clk;
    logic              rst;
    logic              in_valid;
    buffer_pkg::byte_t in_data;
    logic              flush;
    logic              hold;
    logic              in_full;
    logic              level_high;
    logic              level_low;
    logic              out_valid;
    buffer_pkg::byte_t out_data;
    logic              out_last;
    logic              busy;

    buffer_pkg::byte_t model_q[$];     // Accepted bytes, oldest first
    int errors     = 0;
    int checks     = 0;
    int seed       = 26993;
    int flush_sent = 0;                // Flush pulses driven
    int flush_done = 0;                // Flush bursts ended at the output

    byte_stream_buffer u_byte_stream_buffer (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;         // 8 ns period
    end

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("** Error %s: expected %0h, actual %0h", name, exp_v, act_v);
        end
    endtask

    // Byte is dropped by the model once it holds DEPTH words
    task automatic write_byte(input buffer_pkg::byte_t b);
        @(posedge clk);
        in_valid <= 1'b1;
        in_data  <= b;
        flush    <= 1'b0;
        if (model_q.size() < DEPTH) begin
            model_q.push_back(b);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
            flush    <= 1'b0;
        end
    endtask

    task automatic drive_hold(input logic v);
        @(posedge clk);
        in_valid <= 1'b0;
        flush    <= 1'b0;
        hold     <= v;
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        in_valid <= 1'b0;
        flush    <= 1'b1;              // Cleared by the next command
        flush_sent++;
    endtask

    task automatic wait_idle(input int line_no);
        int n;
        n = 0;
        idle_cycles(1);
        @(negedge clk);
        while (busy && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            errors++;
            $display("Timeout at pattern line %0d: busy still high after %0d cycles",
                     line_no, WAIT_MAX);
        end
    endtask

    // Status nibble {in_full, level_high, level_low, busy}
    task automatic check_status(input logic [3:0] exp_s, input int line_no);
        idle_cycles(1);
        @(negedge clk);
        check_value($sformatf("status line %0d", line_no), 32'(exp_s),
                    32'({in_full, level_high, level_low, busy}));
    endtask

    // Output monitor, one word per out_valid
    initial begin : monitor_out
        buffer_pkg::byte_t exp_b;
        logic              exp_last;
        logic              in_flush;   // Current burst drains to empty
        int                burst_pos;  // Words seen in the current burst
        int                words_out;
        in_flush  = 1'b0;
        burst_pos = 0;
        words_out = 0;
        forever begin
            @(negedge clk);
            if (rst && out_valid) begin
                if (model_q.size() == 0) begin
                    errors++;
                    $display("Output word %0d came out with no byte left in the model",
                             words_out);
                end else begin
                    if (burst_pos == 0) begin
                        in_flush = (flush_sent > flush_done);  // Type set at first word
                    end
                    exp_b = model_q.pop_front();
                    burst_pos++;
                    exp_last = in_flush ? (model_q.size() == 0) : (burst_pos == BURST_LEN);
                    check_value($sformatf("out_data word %0d", words_out), 32'(exp_b),
                                32'(out_data));
                    check_value($sformatf("out_last word %0d", words_out), 32'(exp_last),
                                32'(out_last));
                    if (exp_last) begin
                        burst_pos = 0;
                        flush_done += in_flush ? 1 : 0;
                    end
                end
                words_out++;
            end
        end
    end

    initial begin : run_patterns
        int    fd;
        int    line_no;
        int    arg;
        byte   cmd;
        string line;
        rst      = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        flush    = 1'b0;
        hold     = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_value("out_valid after reset", 32'd0, 32'(out_valid));
        fd = $fopen("sim/buffer_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open sim/buffer_patterns.txt");
        end else begin
            line_no = 0;
            while ($fgets(line, fd) > 0) begin
                line_no++;
                cmd = line.getc(0);
                arg = 0;
                if ($sscanf(line.substr(1, line.len() - 1), "%h", arg) != 1) begin
                    arg = 0;           // Commands without an argument
                end
                case (cmd)
                    "W": write_byte(arg[7:0]);
                    "N": repeat (arg) write_byte(buffer_pkg::byte_t'($random(seed)));
                    "H": drive_hold(arg[0]);
                    "F": pulse_flush();
                    "I": idle_cycles(arg);
                    "E": wait_idle(line_no);
                    "S": check_status(arg[3:0], line_no);
                    "#", "\n", " ": ;  // Comment or blank line
                    default: begin
                        errors++;
                        $display("Unknown command on pattern line %0d", line_no);
                    end
                endcase
            end
            $fclose(fd);
        end
        idle_cycles(4);
        check_value("words left in model", 32'd0, 32'(model_q.size()));
        errors += u_byte_stream_buffer.u_props.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, u_byte_stream_buffer.u_props.fail_count);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: sim/buffer_patterns.txt
# Command letter, then hex argument. W byte, N count of seeded random bytes, H hold 0/1,
# F flush, I idle cycles, E wait for busy low, S status {in_full,level_high,level_low,busy}
S 2
H 1
N 2f
S 0
W 5a
S 4
N 0f
W a5
S c
N 06
S c
H 0
E
S 0
F
E
S 2
N 2f
W 3c
W c3
W 77
N 14
E
F
E
S 2
H 1
N 32
S 4
H 0
I 5
F
E
S 2

// File: byte_stream_buffer.f
verilog/buffer_pkg.sv
verilog/fifo_ram.sv
verilog/fifo_sync.sv
verilog/burst_drain.sv
verilog/byte_stream_buffer.sv
sim/byte_stream_buffer_properties.sv
sim/byte_stream_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the byte_stream_buffer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module byte_stream_buffer_tb \
    -f byte_stream_buffer.f -o byte_stream_buffer_sim
./obj_dir/byte_stream_buffer_sim +verilator+error+limit+100 | tee sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
